/* hw/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data word and PC width
`define CORE_XLEN 32

// PC after reset
`define CORE_RESET_PC 32'h0000_0000

// Instruction memory word-address width, 256 words
`define CORE_IMEM_AW 8

// Data memory word-address width, 64 words
// Higher address bits are ignored so accesses wrap
`define CORE_DMEM_AW 6

// tohost CSR number
`define CORE_CSR_TOHOST 12'h51E

`endif

/* hw/core_pkg.sv */
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]    word_t;
    typedef logic [4:0]               reg_idx_t;
    typedef logic [`CORE_IMEM_AW-1:0] imem_addr_t;

    // Major opcodes still handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ADD must stay at zero, an all-zero ctrl is a bubble
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef struct packed {
        logic    reg_we;
        logic    mem_we;
        logic    is_branch;
        logic    is_jump;
        logic    is_csr;
        logic    csr_imm;
        logic    a_is_pc;
        logic    b_is_imm;
        alu_op_e alu_op;
        wb_sel_e wb_sel;
    } ctrl_t;

    // Register file write as seen on the retire port
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        logic       we;
        imem_addr_t addr;
        word_t      data;
    } prog_wr_t;

endpackage

`default_nettype wire

/* hw/sync_ram.sv */
`default_nettype none

module sync_ram #(
    parameter int AW = 8
) (
    input  logic            clk,
    input  logic            we,
    input  logic [AW-1:0]   waddr,
    input  core_pkg::word_t wdata,
    input  logic [AW-1:0]   raddr,
    output core_pkg::word_t rdata
);
    import core_pkg::*;

    localparam int DEPTH = 1 << AW;

    word_t mem [DEPTH];

    // Start from a cleared array
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Read returns old contents on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* hw/regfile.sv */
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               we,
    input  core_pkg::reg_idx_t wa,
    input  core_pkg::word_t    wd,
    input  core_pkg::reg_idx_t ra1,
    input  core_pkg::reg_idx_t ra2,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2
);
    import core_pkg::*;

    word_t regs [32];

    // Start from cleared registers
    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
    end

    // x0 reads zero, a write in flight is passed straight through
    function automatic word_t read_port(input reg_idx_t ra);
        if (ra == '0) begin
            return '0;
        end else if (we && wa == ra) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = read_port(ra1);
    assign rd2 = read_port(ra2);

    // Writeback already drops rd == x0
    a_no_x0_write: assert property (@(posedge clk) we |-> wa != '0)
        else $error("regfile write to x0");

endmodule

`default_nettype wire

/* hw/decoder.sv */
`default_nettype none
`include "core_cfg.svh"

module decoder (
    input  core_pkg::word_t instr,
    output core_pkg::ctrl_t ctrl,
    output core_pkg::word_t imm
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    alu_op_e    arith_op;
    imm_sel_e   imm_sel;

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // Shared by OP and OP-IMM, SUB exists only in OP
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // Anything not matched stays an all-zero bubble
    always_comb begin
        ctrl    = '0;
        imm_sel = IMM_I;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = arith_op;
            end
            OPC_OP_IMM: begin
                ctrl.reg_we   = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = arith_op;
            end
            OPC_LUI: begin
                ctrl.reg_we   = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_PASS_B;
                imm_sel       = IMM_U;
            end
            OPC_LOAD: begin
                // Word loads only
                ctrl.reg_we   = (funct3 == 3'b010);
                ctrl.b_is_imm = 1'b1;
                ctrl.wb_sel   = WB_MEM;
            end
            OPC_STORE: begin
                ctrl.mem_we   = (funct3 == 3'b010);
                ctrl.b_is_imm = 1'b1;
                imm_sel       = IMM_S;
            end
            OPC_BRANCH: begin
                // ALU forms the target, funct3 010 and 011 are reserved
                ctrl.is_branch = (funct3[2:1] != 2'b01);
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                imm_sel        = IMM_B;
            end
            OPC_JAL: begin
                ctrl.reg_we   = 1'b1;
                ctrl.is_jump  = 1'b1;
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.wb_sel   = WB_PC4;
                imm_sel       = IMM_J;
            end
            OPC_SYSTEM: begin
                // CSRRW and CSRRWI to tohost, rd is never written
                if (instr[31:20] == `CORE_CSR_TOHOST && funct3[1:0] == 2'b01) begin
                    ctrl.is_csr  = 1'b1;
                    ctrl.csr_imm = funct3[2];
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_sel)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        a_alu_op_legal: assert (ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
            ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B})
            else $error("decoder produced an illegal alu_op");
    end

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
`default_nettype none

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               valid,
    input  core_pkg::ctrl_t    ctrl,
    input  core_pkg::word_t    pc,
    input  core_pkg::word_t    imm,
    input  core_pkg::word_t    rs1,
    input  core_pkg::word_t    rs2,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    input  logic [2:0]         funct3,
    input  core_pkg::reg_idx_t csr_uimm,
    input  core_pkg::retire_t  wb_fwd,
    input  logic               csr_wr,
    output core_pkg::word_t    alu_res,
    output core_pkg::word_t    store_data,
    output logic               redirect,
    output core_pkg::word_t    target,
    output core_pkg::word_t    tohost
);
    import core_pkg::*;

    word_t      src_a;
    word_t      src_b;
    word_t      alu_a;
    word_t      alu_b;
    logic [4:0] shamt;
    logic       br_taken;
    word_t      csr_src;
    word_t      csr_data_q;

    ////////////////////
    // Operands
    ////////////////////

    // wb_fwd.valid is never set for x0
    assign src_a = (wb_fwd.valid && wb_fwd.rd == rs1_idx) ? wb_fwd.data : rs1;
    assign src_b = (wb_fwd.valid && wb_fwd.rd == rs2_idx) ? wb_fwd.data : rs2;

    assign alu_a      = ctrl.a_is_pc ? pc : src_a;
    assign alu_b      = ctrl.b_is_imm ? imm : src_b;
    assign shamt      = alu_b[4:0];
    assign store_data = src_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = alu_a + alu_b;
            ALU_SUB:    alu_res = alu_a - alu_b;
            ALU_SLL:    alu_res = alu_a << shamt;
            ALU_SLT:    alu_res = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU:   alu_res = word_t'(alu_a < alu_b);
            ALU_XOR:    alu_res = alu_a ^ alu_b;
            ALU_SRL:    alu_res = alu_a >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(alu_a) >>> shamt);
            ALU_OR:     alu_res = alu_a | alu_b;
            ALU_AND:    alu_res = alu_a & alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = '0;
        endcase
    end

    ////////////////////
    // Branch resolve
    ////////////////////

    always_comb begin
        case (funct3)
            3'b000:  br_taken = (src_a == src_b);
            3'b001:  br_taken = (src_a != src_b);
            3'b100:  br_taken = ($signed(src_a) < $signed(src_b));
            3'b101:  br_taken = ($signed(src_a) >= $signed(src_b));
            3'b110:  br_taken = (src_a < src_b);
            3'b111:  br_taken = (src_a >= src_b);
            default: br_taken = 1'b0;
        endcase
    end

    // Branch and JAL both compute PC + imm in the ALU
    assign redirect = valid && (ctrl.is_jump || (ctrl.is_branch && br_taken));
    assign target   = alu_res;

    ////////////////////
    // tohost CSR
    ////////////////////

    assign csr_src = ctrl.csr_imm ? word_t'(csr_uimm) : src_a;

    // Travels alongside the ALU result into writeback
    always_ff @(posedge clk) begin
        csr_data_q <= csr_src;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tohost <= '0;
        end else if (csr_wr) begin
            tohost <= csr_data_q;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> target[1:0] == 2'b00)
        else $error("redirect to a misaligned target");

endmodule

`default_nettype wire

/* hw/riscv_core.sv */
`default_nettype none
`include "core_cfg.svh"

module riscv_core (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::prog_wr_t prog,
    output core_pkg::retire_t  retire,
    output core_pkg::word_t    tohost,
    output logic               tohost_valid
);
    import core_pkg::*;

    typedef struct packed {
        ctrl_t      ctrl;
        word_t      imm;
        word_t      pc;
        word_t      rs1;
        word_t      rs2;
        reg_idx_t   rs1_idx;
        reg_idx_t   rs2_idx;
        reg_idx_t   rd;
        logic [2:0] funct3;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_res;
        word_t    pc;
        reg_idx_t rd;
    } ex_wb_t;

    word_t  pc;
    word_t  id_pc;
    word_t  instr;
    logic   id_valid;
    logic   ex_valid;
    logic   wb_valid;
    ctrl_t  id_ctrl;
    word_t  id_imm;
    word_t  rf_rd1;
    word_t  rf_rd2;
    id_ex_t ex_q;
    ex_wb_t wb_q;
    word_t  alu_res;
    word_t  store_data;
    word_t  target;
    logic   redirect;
    logic   dmem_we;
    word_t  dmem_rdata;
    word_t  wb_data;
    logic   csr_wr;

    ////////////////////
    // Fetch
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Program load owns the write side
    sync_ram #(.AW(`CORE_IMEM_AW)) imem (
        .clk(clk),
        .we(prog.we), .waddr(prog.addr), .wdata(prog.data),
        .raddr(pc[`CORE_IMEM_AW+1:2]), .rdata(instr)
    );

    // Redirect kills decode and execute at the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            id_valid <= !redirect;
            ex_valid <= id_valid && !redirect;
            wb_valid <= ex_valid;
        end
    end

    ////////////////////
    // Decode
    ////////////////////

    decoder decoder (.instr(instr), .ctrl(id_ctrl), .imm(id_imm));

    regfile regfile (
        .clk(clk),
        .we(retire.valid), .wa(retire.rd), .wd(retire.data),
        .ra1(instr[19:15]), .ra2(instr[24:20]),
        .rd1(rf_rd1), .rd2(rf_rd2)
    );

    always_ff @(posedge clk) begin
        id_pc        <= pc;
        ex_q.ctrl    <= id_ctrl;
        ex_q.imm     <= id_imm;
        ex_q.pc      <= id_pc;
        ex_q.rs1     <= rf_rd1;
        ex_q.rs2     <= rf_rd2;
        ex_q.rs1_idx <= instr[19:15];
        ex_q.rs2_idx <= instr[24:20];
        ex_q.rd      <= instr[11:7];
        ex_q.funct3  <= instr[14:12];
        wb_q.ctrl    <= ex_q.ctrl;
        wb_q.alu_res <= alu_res;
        wb_q.pc      <= ex_q.pc;
        wb_q.rd      <= ex_q.rd;
    end

    ////////////////////
    // Execute
    ////////////////////

    // The rs1 field doubles as the CSRRWI immediate
    execute_unit execute_unit (
        .clk(clk), .rst_n(rst_n), .valid(ex_valid), .ctrl(ex_q.ctrl),
        .pc(ex_q.pc), .imm(ex_q.imm), .rs1(ex_q.rs1), .rs2(ex_q.rs2),
        .rs1_idx(ex_q.rs1_idx), .rs2_idx(ex_q.rs2_idx), .funct3(ex_q.funct3),
        .csr_uimm(ex_q.rs1_idx), .wb_fwd(retire), .csr_wr(csr_wr),
        .alu_res(alu_res), .store_data(store_data), .redirect(redirect),
        .target(target), .tohost(tohost)
    );

    assign dmem_we = ex_valid && ex_q.ctrl.mem_we;

    sync_ram #(.AW(`CORE_DMEM_AW)) dmem (
        .clk(clk),
        .we(dmem_we), .waddr(alu_res[`CORE_DMEM_AW+1:2]), .wdata(store_data),
        .raddr(alu_res[`CORE_DMEM_AW+1:2]), .rdata(dmem_rdata)
    );

    ////////////////////
    // Writeback
    ////////////////////

    always_comb begin
        case (wb_q.ctrl.wb_sel)
            WB_MEM:  wb_data = dmem_rdata;
            WB_PC4:  wb_data = wb_q.pc + 32'd4;
            default: wb_data = wb_q.alu_res;
        endcase
    end

    assign retire.valid = wb_valid && wb_q.ctrl.reg_we && (wb_q.rd != '0);
    assign retire.rd    = wb_q.rd;
    assign retire.data  = wb_data;
    assign csr_wr       = wb_valid && wb_q.ctrl.is_csr;

    // Delayed one cycle so the strobe lines up with the updated tohost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tohost_valid <= 1'b0;
        end else begin
            tohost_valid <= csr_wr;
        end
    end

    a_redirect_kills_ex: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !ex_valid)
        else $error("instruction behind a redirect reached execute");

endmodule

`default_nettype wire

/* sim/ref_model.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////
// Instruction encoding
////////////////////

function automatic word_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t store_word(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic word_t branch_word(input logic [12:0] off, input logic [2:0] f3,
                                      input reg_idx_t rs2, input reg_idx_t rs1);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic word_t jal_word(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Only x0..x7 so that dependencies show up often
function automatic reg_idx_t pick_reg();
    return reg_idx_t'(next_random() % 32'd8);
endfunction

////////////////////
// Random program
////////////////////

function automatic void build_program();
    int          i;
    int          kind;
    int          skip;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    i = 0;
    while (i < PROG_LEN - 1) begin
        kind = int'(next_random() % 32'd16);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = 3'(next_random());
        imm  = 12'(next_random());
        skip = 1 + int'(next_random() % 32'd3);
        alt  = (f3 == 3'd0 || f3 == 3'd5) && imm[0];
        if (kind < 5) begin
            program_words[i] = r_type_word({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        end else if (kind < 9) begin
            // Shifts carry the arithmetic flag in bit 30
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, f3[2] & imm[11], 5'b0, imm[4:0]};
            end
            program_words[i] = i_type_word(imm, rs1, f3, rd, OPC_OP_IMM);
        end else if (kind == 9) begin
            program_words[i] = {20'(next_random()), rd, OPC_LUI};
        end else if (kind == 10 && i < PROG_LEN - 2) begin
            // Store, then load straight back from the same address
            program_words[i] = store_word({4'b0, imm[5:0], 2'b00}, rs2, rs1);
            i++;
            program_words[i] = i_type_word({4'b0, imm[5:0], 2'b00}, rs1, 3'b010, rd,
                                           OPC_LOAD);
        end else if (kind == 11) begin
            program_words[i] = i_type_word({4'b0, imm[5:0], 2'b00}, rs1, 3'b010, rd,
                                           OPC_LOAD);
        end else if (kind < 14 && i + skip < PROG_LEN - 1) begin
            // Reserved 010/011 fold onto the unsigned compares
            f3 = {f3[2] | f3[1], f3[1:0]};
            program_words[i] = branch_word(13'((skip + 1) * 4), f3, rs2, rs1);
        end else if (kind == 14 && i + skip < PROG_LEN - 1) begin
            program_words[i] = jal_word(21'((skip + 1) * 4), rd);
        end else if (kind == 15) begin
            program_words[i] = i_type_word(`CORE_CSR_TOHOST,
                                           f3[2] ? 5'(next_random()) : rs1,
                                           {f3[2], 2'b01}, rd, OPC_SYSTEM);
        end else begin
            program_words[i] = i_type_word(imm, rs1, 3'b000, rd, OPC_OP_IMM);
        end
        i++;
    end
    // Park on a jump to itself
    program_words[PROG_LEN - 1] = jal_word(21'd0, 5'd0);
endfunction

////////////////////
// ISA model
////////////////////

function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
    logic signed [31:0] sra;
    sra = $signed(a) >>> b[4:0];
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'(sra) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic void run_model();
    word_t      regs [32];
    word_t      mem_words [1 << `CORE_DMEM_AW];
    word_t      pc;
    word_t      next_pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      addr;
    word_t      res;
    logic       wr;
    logic [2:0] f3;
    reg_idx_t   rd;
    retire_t    item;
    int         steps;
    foreach (regs[k]) regs[k] = '0;
    foreach (mem_words[k]) mem_words[k] = '0;
    pc    = '0;
    steps = 0;
    while (pc != word_t'((PROG_LEN - 1) * 4) && steps < PROG_LEN) begin
        ins     = program_words[pc[9:2]];
        rd      = ins[11:7];
        f3      = ins[14:12];
        a       = regs[ins[19:15]];
        b       = regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        res     = '0;
        wr      = 1'b0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            OPC_OP: begin
                res = alu_result(f3, ins[30], a, b);
                wr  = 1'b1;
            end
            OPC_OP_IMM: begin
                res = alu_result(f3, f3 == 3'd5 && ins[30], a, imm_i);
                wr  = 1'b1;
            end
            OPC_LUI: begin
                res = {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            OPC_LOAD: begin
                addr = a + imm_i;
                res  = mem_words[addr[`CORE_DMEM_AW+1:2]];
                wr   = 1'b1;
            end
            OPC_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem_words[addr[`CORE_DMEM_AW+1:2]] = b;
            end
            OPC_BRANCH: begin
                if (branch_taken(f3, a, b)) begin
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                res     = pc + 32'd4;
                wr      = 1'b1;
                next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                ins[30:21], 1'b0};
            end
            OPC_SYSTEM: begin
                exp_tohost.push_back(f3[2] ? word_t'(ins[19:15]) : a);
            end
            default: ;
        endcase
        if (wr && rd != 5'd0) begin
            regs[rd]   = res;
            item.valid = 1'b1;
            item.rd    = rd;
            item.data  = res;
            exp_retire.push_back(item);
        end
        pc = next_pc;
        steps++;
    end
endfunction

`endif

/* sim/tb_riscv_core.sv */
`default_nettype none
`include "core_cfg.svh"

module tb_riscv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int PROG_LEN     = 200;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 10;
    // Load, reset, four cycles per instruction and some slack
    localparam int WATCHDOG_CYCLES = PROG_LEN + RESET_CYCLES + 4 * PROG_LEN + 50;

    logic     clk = 1'b0;
    logic     rst_n = 1'b0;
    prog_wr_t prog = '0;
    retire_t  retire;
    word_t    tohost;
    logic     tohost_valid;

    word_t       program_words [PROG_LEN];
    retire_t     exp_retire [$];
    word_t       exp_tohost [$];
    int unsigned lcg_state = 40;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    `include "ref_model.svh"

    riscv_core uut (
        .clk(clk),
        .rst_n(rst_n),
        .prog(prog),
        .retire(retire),
        .tohost(tohost),
        .tohost_valid(tohost_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.rd !== exp.rd) begin
            stop_with_failure($sformatf("** Error: retire.rd = %h, expected %h",
                                        got.rd, exp.rd));
        end else if (got.data !== exp.data) begin
            stop_with_failure($sformatf("** Error: retire.data = %h, expected %h",
                                        got.data, exp.data));
        end
    endtask

    task automatic check_tohost(input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error: tohost = %h, expected %h", got, exp));
        end
    endtask

    // Outputs are sampled half a cycle after the edge
    always @(negedge clk) begin
        if (!rst_n && retire.valid !== 1'b0) begin
            stop_with_failure("retire.valid was not low during reset");
        end else if (retire.valid === 1'b1) begin
            if (exp_retire.size() == 0) begin
                stop_with_failure("A register write retired when none was left to expect");
            end else begin
                check_retire(retire, exp_retire.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n && tohost_valid !== 1'b0) begin
            stop_with_failure("tohost_valid was not low during reset");
        end else if (tohost_valid === 1'b1) begin
            if (exp_tohost.size() == 0) begin
                stop_with_failure("A tohost write appeared when none was left to expect");
            end else begin
                check_tohost(tohost, exp_tohost.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog expired before the program finished retiring");
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int n_writes;
        int n_tohost;
        build_program();
        run_model();
        n_writes = exp_retire.size();
        n_tohost = exp_tohost.size();
        // Program goes in while the core is held in reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            prog <= '{we: 1'b1, addr: imem_addr_t'(i), data: program_words[i]};
        end
        @(posedge clk);
        prog <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (exp_retire.size() != 0 || exp_tohost.size() != 0) begin
            @(posedge clk);
        end
        // Nothing more may retire after the last expected write
        repeat (20) @(posedge clk);
        $display("Checked %0d register writes and %0d tohost writes", n_writes, n_tohost);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* riscv_core.f */
+incdir+hw
+incdir+sim
hw/core_pkg.sv
hw/sync_ram.sv
hw/regfile.sv
hw/decoder.sv
hw/execute_unit.sv
hw/riscv_core.sv
sim/tb_riscv_core.sv

/* Makefile */
# Build and run the riscv_core testbench with Verilator

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f riscv_core.f --top-module tb_riscv_core -o Vtb_riscv_core
	./obj_dir/Vtb_riscv_core

clean:
	rm -rf obj_dir

.PHONY: sim clean
